/* verilog/flow_table_defs.svh */
`ifndef FLOW_TABLE_DEFS_SVH
`define FLOW_TABLE_DEFS_SVH

// Table geometry
`define FT_SUBTABLES 4
`define FT_AWIDTH 4
`define FT_DEPTH (1 << `FT_AWIDTH)

// All ones in a queue id means drop
`define FT_QID_WIDTH 10

// Subtable k is seeded with k times the step
`define FT_HASH_SEED_STEP 32'h9E3779B9
`define FT_HASH_MULT 32'h85EBCA6B

`endif

/* verilog/flow_table_pkg.sv */
`include "flow_table_defs.svh"

package flow_table_pkg;

    typedef struct packed {
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
    } tuple_t;

    typedef logic [`FT_QID_WIDTH-1:0] qid_t;

    typedef struct packed {
        tuple_t      tuple;
        qid_t        pkt_queue_id;
        qid_t        dsc_queue_id;
        logic [15:0] pkt_len;
    } metadata_t;

    typedef struct packed {
        tuple_t tuple;
        qid_t   pkt_queue_id;
        qid_t   dsc_queue_id;
    } ctrl_cmd_t;

    typedef struct packed {
        logic   valid;
        tuple_t tuple;
        qid_t   pkt_queue_id;
        qid_t   dsc_queue_id;
    } entry_t;

    typedef logic [`FT_AWIDTH-1:0] slot_idx_t;
    typedef slot_idx_t [`FT_SUBTABLES-1:0] slot_vec_t;

    typedef enum logic [1:0] {
        place_update,
        place_insert,
        place_reject
    } place_code_t;

    typedef struct packed {
        logic        done;
        place_code_t code;
    } ctrl_result_t;

    typedef struct packed {
        logic      rd_en;
        logic      wr_en;
        slot_idx_t idx;
        entry_t    wr_entry;
    } port_req_t;

endpackage

/* verilog/tuple_hash.sv */
`include "flow_table_defs.svh"

module tuple_hash #(
    parameter type payload_t = logic
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      advance,
    input  logic                      in_valid,
    input  flow_table_pkg::tuple_t    in_tuple,
    input  payload_t                  in_payload,
    output logic                      out_valid,
    output flow_table_pkg::slot_vec_t out_idx,
    output payload_t                  out_payload
);

    logic [31:0]                     fold;
    logic [`FT_SUBTABLES-1:0][31:0] key_q;
    logic                            key_valid_q;
    payload_t                        key_payload_q;

    assign fold = in_tuple.src_ip ^ in_tuple.dst_ip ^ {in_tuple.src_port, in_tuple.dst_port};

    always_ff @(posedge clk) begin
        if (rst) begin
            key_valid_q <= 1'b0;
            out_valid <= 1'b0;
        end else if (advance) begin
            key_valid_q <= in_valid;
            out_valid <= key_valid_q;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            key_payload_q <= in_payload;
            out_payload <= key_payload_q;
        end
    end

    for (genvar k = 0; k < `FT_SUBTABLES; k++) begin : g_seed
        localparam logic [31:0] seed = 32'(k) * `FT_HASH_SEED_STEP;
        logic [31:0] prod;

        // Product wraps at 32 bits, index is the top slice
        assign prod = key_q[k] * `FT_HASH_MULT;

        always_ff @(posedge clk) begin
            if (advance) begin
                key_q[k] <= fold ^ seed;
                out_idx[k] <= prod[31 -: `FT_AWIDTH];
            end
        end
    end

endmodule

/* verilog/flow_subtable.sv */
`include "flow_table_defs.svh"

module flow_subtable (
    input  logic                      clk,
    input  logic                      rst,
    input  flow_table_pkg::port_req_t req_a,
    input  flow_table_pkg::port_req_t req_b,
    input  logic                      advance_a,
    output flow_table_pkg::entry_t    rd_a,
    output flow_table_pkg::entry_t    rd_b
);

    flow_table_pkg::entry_t mem [`FT_DEPTH];
    logic [`FT_DEPTH-1:0]   valid_q;
    flow_table_pkg::entry_t rd_a_q;
    flow_table_pkg::entry_t rd_b_q;

    // Only port B writes
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (req_b.wr_en) begin
            valid_q[req_b.idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (req_b.wr_en) begin
            mem[req_b.idx] <= req_b.wr_entry;
        end
    end

    // Two-stage reads, valid bit taken from the vector
    always_ff @(posedge clk) begin
        if (advance_a) begin
            if (req_a.rd_en) begin
                rd_a_q <= mem[req_a.idx];
                rd_a_q.valid <= valid_q[req_a.idx];
            end
            rd_a <= rd_a_q;
        end
        if (req_b.rd_en) begin
            rd_b_q <= mem[req_b.idx];
            rd_b_q.valid <= valid_q[req_b.idx];
        end
        rd_b <= rd_b_q;
    end

endmodule

/* verilog/flow_lookup.sv */
`include "flow_table_defs.svh"

module flow_lookup (
    input  logic                                          clk,
    input  logic                                          rst,
    input  flow_table_pkg::metadata_t                     in_meta_data,
    input  logic                                          in_meta_valid,
    output logic                                          in_meta_ready,
    output flow_table_pkg::metadata_t                     out_meta_data,
    output logic                                          out_meta_valid,
    input  logic                                          out_meta_ready,
    output flow_table_pkg::port_req_t [`FT_SUBTABLES-1:0] req_a,
    output logic                                          advance_a,
    input  flow_table_pkg::entry_t [`FT_SUBTABLES-1:0]    rd_a
);

    logic                      h_valid;
    flow_table_pkg::slot_vec_t h_idx;
    flow_table_pkg::metadata_t h_meta;

    logic                      addr_valid;
    flow_table_pkg::slot_vec_t addr_idx;
    flow_table_pkg::metadata_t addr_meta;

    logic                      rd1_valid;
    logic                      rd2_valid;
    flow_table_pkg::metadata_t rd1_meta;
    flow_table_pkg::metadata_t rd2_meta;

    logic [`FT_SUBTABLES-1:0]  hit;
    flow_table_pkg::metadata_t result;

    // Whole pipeline stalls on downstream backpressure
    assign in_meta_ready = out_meta_ready;
    assign advance_a = out_meta_ready;

    tuple_hash #(
        .payload_t (flow_table_pkg::metadata_t)
    ) u_hash (
        .clk         (clk),
        .rst         (rst),
        .advance     (advance_a),
        .in_valid    (in_meta_valid & in_meta_ready),
        .in_tuple    (in_meta_data.tuple),
        .in_payload  (in_meta_data),
        .out_valid   (h_valid),
        .out_idx     (h_idx),
        .out_payload (h_meta)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            addr_valid <= 1'b0;
            rd1_valid <= 1'b0;
            rd2_valid <= 1'b0;
            out_meta_valid <= 1'b0;
        end else if (advance_a) begin
            addr_valid <= h_valid;
            rd1_valid <= addr_valid;
            rd2_valid <= rd1_valid;
            out_meta_valid <= rd2_valid;
        end
    end

    // Metadata rides alongside the subtable read
    always_ff @(posedge clk) begin
        if (advance_a) begin
            addr_idx <= h_idx;
            addr_meta <= h_meta;
            rd1_meta <= addr_meta;
            rd2_meta <= rd1_meta;
            if (rd2_valid) begin
                out_meta_data <= result;
            end
        end
    end

    for (genvar k = 0; k < `FT_SUBTABLES; k++) begin : g_port
        assign req_a[k].rd_en = addr_valid;
        assign req_a[k].wr_en = 1'b0;
        assign req_a[k].idx = addr_idx[k];
        assign req_a[k].wr_entry = '0;
        assign hit[k] = rd_a[k].valid && (rd_a[k].tuple == rd2_meta.tuple);
    end

    // Lowest subtable wins, a miss means drop
    always_comb begin
        result = rd2_meta;
        result.pkt_queue_id = '1;
        result.dsc_queue_id = '1;
        for (int k = `FT_SUBTABLES - 1; k >= 0; k--) begin
            if (hit[k]) begin
                result.pkt_queue_id = rd_a[k].pkt_queue_id;
                result.dsc_queue_id = rd_a[k].dsc_queue_id;
            end
        end
    end

endmodule

/* verilog/flow_placement.sv */
`include "flow_table_defs.svh"

module flow_placement (
    input  logic                                          clk,
    input  logic                                          rst,
    input  flow_table_pkg::ctrl_cmd_t                     in_control_data,
    input  logic                                          in_control_valid,
    output logic                                          in_control_ready,
    output flow_table_pkg::port_req_t [`FT_SUBTABLES-1:0] req_b,
    input  flow_table_pkg::entry_t [`FT_SUBTABLES-1:0]    rd_b,
    output flow_table_pkg::ctrl_result_t                  out_control_result
);

    typedef enum logic [1:0] {
        st_idle,
        st_hashing,
        st_reading,
        st_deciding
    } state_t;

    state_t                      state;
    logic                        accept;

    logic                        h_valid;
    flow_table_pkg::slot_vec_t   h_idx;
    flow_table_pkg::ctrl_cmd_t   h_cmd;

    flow_table_pkg::ctrl_cmd_t   cmd_q;
    flow_table_pkg::slot_vec_t   idx_q;
    flow_table_pkg::entry_t      wr_entry;
    logic                        rd_en_q;
    logic                        rd_v1;
    logic                        rd_v2;
    logic [`FT_SUBTABLES-1:0]    wr_sel_q;

    logic [`FT_SUBTABLES-1:0]    hit;
    logic [`FT_SUBTABLES-1:0]    empty;
    logic [`FT_SUBTABLES-1:0]    wr_sel;
    flow_table_pkg::place_code_t code;

    assign in_control_ready = (state == st_idle);
    assign accept = in_control_valid & in_control_ready;

    // Hash runs freely, the FSM catches its one-cycle valid
    tuple_hash #(
        .payload_t (flow_table_pkg::ctrl_cmd_t)
    ) u_hash (
        .clk         (clk),
        .rst         (rst),
        .advance     (1'b1),
        .in_valid    (accept),
        .in_tuple    (in_control_data.tuple),
        .in_payload  (in_control_data),
        .out_valid   (h_valid),
        .out_idx     (h_idx),
        .out_payload (h_cmd)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            rd_en_q <= 1'b0;
            rd_v1 <= 1'b0;
            rd_v2 <= 1'b0;
            wr_sel_q <= '0;
            out_control_result <= '0;
        end else begin
            rd_v1 <= rd_en_q;
            rd_v2 <= rd_v1;
            case (state)
                st_idle: begin
                    if (accept) begin
                        state <= st_hashing;
                    end
                end
                st_hashing: begin
                    if (h_valid) begin
                        rd_en_q <= 1'b1;
                        state <= st_reading;
                    end
                end
                st_reading: begin
                    rd_en_q <= 1'b0;
                    if (rd_v2) begin
                        wr_sel_q <= wr_sel;
                        out_control_result.code <= code;
                        state <= st_deciding;
                    end
                end
                st_deciding: begin
                    // Write lands on the same edge as done
                    if (!out_control_result.done) begin
                        wr_sel_q <= '0;
                        out_control_result.done <= 1'b1;
                    end else begin
                        out_control_result.done <= 1'b0;
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_hashing && h_valid) begin
            cmd_q <= h_cmd;
            idx_q <= h_idx;
        end
    end

    assign wr_entry.valid = 1'b1;
    assign wr_entry.tuple = cmd_q.tuple;
    assign wr_entry.pkt_queue_id = cmd_q.pkt_queue_id;
    assign wr_entry.dsc_queue_id = cmd_q.dsc_queue_id;

    for (genvar k = 0; k < `FT_SUBTABLES; k++) begin : g_port
        assign req_b[k].rd_en = rd_en_q;
        assign req_b[k].wr_en = wr_sel_q[k];
        assign req_b[k].idx = idx_q[k];
        assign req_b[k].wr_entry = wr_entry;
        assign hit[k] = rd_b[k].valid && (rd_b[k].tuple == cmd_q.tuple);
        assign empty[k] = !rd_b[k].valid;
    end

    // Update beats insert; neither means reject
    always_comb begin
        wr_sel = '0;
        code = flow_table_pkg::place_reject;
        if (|hit) begin
            code = flow_table_pkg::place_update;
            for (int k = `FT_SUBTABLES - 1; k >= 0; k--) begin
                if (hit[k]) begin
                    wr_sel = '0;
                    wr_sel[k] = 1'b1;
                end
            end
        end else if (|empty) begin
            code = flow_table_pkg::place_insert;
            for (int k = `FT_SUBTABLES - 1; k >= 0; k--) begin
                if (empty[k]) begin
                    wr_sel = '0;
                    wr_sel[k] = 1'b1;
                end
            end
        end
    end

endmodule

/* verilog/flow_table.sv */
`include "flow_table_defs.svh"

module flow_table (
    input  logic                         clk,
    input  logic                         rst,
    // Packet lookup
    input  flow_table_pkg::metadata_t    in_meta_data,
    input  logic                         in_meta_valid,
    output logic                         in_meta_ready,
    output flow_table_pkg::metadata_t    out_meta_data,
    output logic                         out_meta_valid,
    input  logic                         out_meta_ready,
    // Flow placement
    input  flow_table_pkg::ctrl_cmd_t    in_control_data,
    input  logic                         in_control_valid,
    output logic                         in_control_ready,
    output flow_table_pkg::ctrl_result_t out_control_result
);

    flow_table_pkg::port_req_t [`FT_SUBTABLES-1:0] req_a;
    flow_table_pkg::port_req_t [`FT_SUBTABLES-1:0] req_b;
    flow_table_pkg::entry_t [`FT_SUBTABLES-1:0]    rd_a;
    flow_table_pkg::entry_t [`FT_SUBTABLES-1:0]    rd_b;
    logic                                          advance_a;

    flow_lookup u_lookup (
        .clk            (clk),
        .rst            (rst),
        .in_meta_data   (in_meta_data),
        .in_meta_valid  (in_meta_valid),
        .in_meta_ready  (in_meta_ready),
        .out_meta_data  (out_meta_data),
        .out_meta_valid (out_meta_valid),
        .out_meta_ready (out_meta_ready),
        .req_a          (req_a),
        .advance_a      (advance_a),
        .rd_a           (rd_a)
    );

    flow_placement u_placement (
        .clk                (clk),
        .rst                (rst),
        .in_control_data    (in_control_data),
        .in_control_valid   (in_control_valid),
        .in_control_ready   (in_control_ready),
        .req_b              (req_b),
        .rd_b               (rd_b),
        .out_control_result (out_control_result)
    );

    // Port A serves lookups, port B serves placement
    for (genvar k = 0; k < `FT_SUBTABLES; k++) begin : g_subtable
        flow_subtable u_subtable (
            .clk       (clk),
            .rst       (rst),
            .req_a     (req_a[k]),
            .req_b     (req_b[k]),
            .advance_a (advance_a),
            .rd_a      (rd_a[k]),
            .rd_b      (rd_b[k])
        );
    end

endmodule

/* bench/flow_table_model.svh */
`ifndef FLOW_TABLE_MODEL_SVH
`define FLOW_TABLE_MODEL_SVH

logic [31:0] rng_state = 32'd40;
flow_table_pkg::entry_t model_tab [`FT_SUBTABLES][`FT_DEPTH];

function automatic logic [31:0] xorshift();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

// Fold, seed, multiply, keep the top bits
function automatic flow_table_pkg::slot_idx_t ref_slot(flow_table_pkg::tuple_t t, int k);
    logic [31:0] key;
    logic [31:0] prod;
    key = t.src_ip ^ t.dst_ip ^ {t.src_port, t.dst_port};
    key = key ^ (32'(k) * `FT_HASH_SEED_STEP);
    prod = key * `FT_HASH_MULT;
    return prod[31 -: `FT_AWIDTH];
endfunction

function automatic flow_table_pkg::place_code_t model_place(flow_table_pkg::ctrl_cmd_t cmd);
    int hit_k;
    int empty_k;
    int pick;
    flow_table_pkg::slot_idx_t idx;
    hit_k = -1;
    empty_k = -1;
    for (int k = 0; k < `FT_SUBTABLES; k++) begin
        idx = ref_slot(cmd.tuple, k);
        if (model_tab[k][idx].valid && model_tab[k][idx].tuple == cmd.tuple) begin
            if (hit_k < 0) hit_k = k;
        end else if (!model_tab[k][idx].valid && empty_k < 0) begin
            empty_k = k;
        end
    end
    if (hit_k < 0 && empty_k < 0) return flow_table_pkg::place_reject;
    pick = (hit_k >= 0) ? hit_k : empty_k;
    idx = ref_slot(cmd.tuple, pick);
    model_tab[pick][idx] = {1'b1, cmd.tuple, cmd.pkt_queue_id, cmd.dsc_queue_id};
    return (hit_k >= 0) ? flow_table_pkg::place_update : flow_table_pkg::place_insert;
endfunction

// First matching subtable gives the ids, otherwise drop
function automatic flow_table_pkg::metadata_t model_lookup(flow_table_pkg::metadata_t meta);
    flow_table_pkg::metadata_t res;
    flow_table_pkg::slot_idx_t idx;
    logic found;
    res = meta;
    res.pkt_queue_id = '1;
    res.dsc_queue_id = '1;
    found = 1'b0;
    for (int k = 0; k < `FT_SUBTABLES; k++) begin
        idx = ref_slot(meta.tuple, k);
        if (!found && model_tab[k][idx].valid && model_tab[k][idx].tuple == meta.tuple) begin
            found = 1'b1;
            res.pkt_queue_id = model_tab[k][idx].pkt_queue_id;
            res.dsc_queue_id = model_tab[k][idx].dsc_queue_id;
        end
    end
    return res;
endfunction

`endif

/* bench/flow_table_tb.sv */
`include "flow_table_defs.svh"

module flow_table_tb;

    logic                         clk;
    logic                         rst;
    flow_table_pkg::metadata_t    in_meta_data;
    logic                         in_meta_valid;
    logic                         in_meta_ready;
    flow_table_pkg::metadata_t    out_meta_data;
    logic                         out_meta_valid;
    logic                         out_meta_ready;
    flow_table_pkg::ctrl_cmd_t    in_control_data;
    logic                         in_control_valid;
    logic                         in_control_ready;
    flow_table_pkg::ctrl_result_t out_control_result;

    int                          value_errors = 0;
    int                          other_errors = 0;
    string                       test_name = "reset";
    flow_table_pkg::metadata_t   exp_q [$];
    flow_table_pkg::metadata_t   exp_head;
    logic                        exp_avail;
    flow_table_pkg::place_code_t exp_code;
    flow_table_pkg::tuple_t      placed [$];
    logic                        stall_mode;
    int                          stretch;

    `include "flow_table_model.svh"

    flow_table dut (
        .clk                (clk),
        .rst                (rst),
        .in_meta_data       (in_meta_data),
        .in_meta_valid      (in_meta_valid),
        .in_meta_ready      (in_meta_ready),
        .out_meta_data      (out_meta_data),
        .out_meta_valid     (out_meta_valid),
        .out_meta_ready     (out_meta_ready),
        .in_control_data    (in_control_data),
        .in_control_valid   (in_control_valid),
        .in_control_ready   (in_control_ready),
        .out_control_result (out_control_result)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic void refresh_head();
        exp_avail = (exp_q.size() > 0);
        exp_head = exp_avail ? exp_q[0] : '0;
    endfunction

    always @(posedge clk) begin
        if (!rst && out_meta_valid && out_meta_ready && exp_q.size() > 0) begin
            void'(exp_q.pop_front());
            refresh_head();
        end
    end

    a_reset: assert property (@(posedge clk) rst |=>
        (!out_meta_valid && !out_control_result.done && in_control_ready))
        else begin
            value_errors++;
            $display("[FAIL] %s: expected idle 001, actual %b%b%b", test_name,
                $sampled(out_meta_valid), $sampled(out_control_result.done),
                $sampled(in_control_ready));
        end

    a_ready_follow: assert property (@(posedge clk) in_meta_ready == out_meta_ready)
        else begin
            value_errors++;
            $display("[FAIL] %s: expected %b, actual %b", test_name,
                $sampled(out_meta_ready), $sampled(in_meta_ready));
        end

    a_lookup_data: assert property (@(posedge clk) disable iff (rst)
        (out_meta_valid && out_meta_ready) |-> (exp_avail && out_meta_data == exp_head))
        else begin
            value_errors++;
            $display("[FAIL] %s: expected %h, actual %h", test_name,
                $sampled(exp_head), $sampled(out_meta_data));
        end

    a_hold: assert property (@(posedge clk) disable iff (rst)
        (out_meta_valid && !out_meta_ready) |=> (out_meta_valid && $stable(out_meta_data)))
        else begin
            other_errors++;
            $display("%s: lookup output changed while downstream was not ready", test_name);
        end

    a_lookup_latency: assert property (@(posedge clk) disable iff (rst)
        (in_meta_valid && in_meta_ready) ##1 out_meta_ready [*5] |=> out_meta_valid)
        else begin
            other_errors++;
            $display("%s: lookup result missing 5 cycles after acceptance", test_name);
        end

    a_done_timing: assert property (@(posedge clk) disable iff (rst)
        (in_control_valid && in_control_ready) |=>
        !out_control_result.done [*6] ##1 out_control_result.done ##1 !out_control_result.done)
        else begin
            other_errors++;
            $display("%s: done did not pulse once 6 cycles after acceptance", test_name);
        end

    a_code: assert property (@(posedge clk) disable iff (rst)
        out_control_result.done |-> (out_control_result.code == exp_code))
        else begin
            value_errors++;
            $display("[FAIL] %s: expected %s, actual %s", test_name,
                exp_code.name(), out_control_result.code.name());
        end

    a_control_ready: assert property (@(posedge clk) disable iff (rst)
        (in_control_valid && in_control_ready) |=> !in_control_ready [*7] ##1 in_control_ready)
        else begin
            other_errors++;
            $display("%s: control ready did not stay low until the cycle after done",
                test_name);
        end

    // Random stretches of backpressure
    task automatic step_ready();
        if (stall_mode) begin
            if (stretch == 0) begin
                out_meta_ready = ~out_meta_ready;
                stretch = 1 + int'(xorshift() % 5);
            end
            stretch--;
        end else begin
            out_meta_ready = 1'b1;
        end
    endtask

    function automatic flow_table_pkg::tuple_t random_tuple();
        flow_table_pkg::tuple_t t;
        t.src_ip = xorshift();
        t.dst_ip = xorshift();
        t[31:0] = xorshift();
        return t;
    endfunction

    function automatic flow_table_pkg::metadata_t meta_for(flow_table_pkg::tuple_t t);
        flow_table_pkg::metadata_t m;
        m.tuple = t;
        m.pkt_queue_id = xorshift();
        m.dsc_queue_id = xorshift();
        m.pkt_len = xorshift();
        return m;
    endfunction

    function automatic flow_table_pkg::ctrl_cmd_t cmd_for(flow_table_pkg::tuple_t t);
        flow_table_pkg::ctrl_cmd_t c;
        c.tuple = t;
        c.pkt_queue_id = xorshift();
        c.dsc_queue_id = xorshift();
        return c;
    endfunction

    task automatic send_lookup(input flow_table_pkg::metadata_t meta);
        int waited;
        waited = 0;
        in_meta_data = meta;
        in_meta_valid = 1'b1;
        step_ready();
        while (!out_meta_ready && waited < 100) begin
            @(negedge clk);
            step_ready();
            waited++;
        end
        if (!out_meta_ready) begin
            other_errors++;
            $display("%s: timed out waiting to offer a lookup", test_name);
        end else begin
            exp_q.push_back(model_lookup(meta));
            refresh_head();
        end
        @(negedge clk);
        in_meta_valid = 1'b0;
    endtask

    task automatic drain_lookups();
        int waited;
        waited = 0;
        while (exp_q.size() > 0 && waited < 300) begin
            @(negedge clk);
            step_ready();
            waited++;
        end
        if (exp_q.size() > 0) begin
            other_errors++;
            $display("%s: timed out waiting for %0d lookup results", test_name, exp_q.size());
        end
        stall_mode = 1'b0;
        out_meta_ready = 1'b1;
    endtask

    task automatic send_command(input flow_table_pkg::ctrl_cmd_t cmd,
                                output flow_table_pkg::place_code_t code);
        int waited;
        waited = 0;
        code = flow_table_pkg::place_reject;
        in_control_data = cmd;
        in_control_valid = 1'b1;
        while (!in_control_ready && waited < 50) begin
            @(negedge clk);
            waited++;
        end
        if (!in_control_ready) begin
            other_errors++;
            $display("%s: timed out waiting for control ready", test_name);
        end else begin
            code = model_place(cmd);
            exp_code = code;
        end
        @(negedge clk);
        in_control_valid = 1'b0;
    endtask

    task automatic wait_done();
        int waited;
        waited = 0;
        while (!out_control_result.done && waited < 50) begin
            @(negedge clk);
            waited++;
        end
        if (!out_control_result.done) begin
            other_errors++;
            $display("%s: timed out waiting for placement done", test_name);
        end
        @(negedge clk);
    endtask

    initial begin
        flow_table_pkg::ctrl_cmd_t   cmd;
        flow_table_pkg::ctrl_cmd_t   cmd2;
        flow_table_pkg::place_code_t code;
        int                          tries;

        rst = 1'b1;
        in_meta_data = '0;
        in_meta_valid = 1'b0;
        out_meta_ready = 1'b1;
        in_control_data = '0;
        in_control_valid = 1'b0;
        exp_code = flow_table_pkg::place_reject;
        stall_mode = 1'b0;
        stretch = 0;
        for (int k = 0; k < `FT_SUBTABLES; k++) begin
            for (int i = 0; i < `FT_DEPTH; i++) begin
                model_tab[k][i] = '0;
            end
        end
        refresh_head();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_name = "miss_after_reset";
        for (int i = 0; i < 4; i++) begin
            send_lookup(meta_for(random_tuple()));
        end
        drain_lookups();

        test_name = "insert";
        cmd = cmd_for(random_tuple());
        send_command(cmd, code);
        wait_done();
        placed.push_back(cmd.tuple);
        send_lookup(meta_for(cmd.tuple));
        drain_lookups();

        test_name = "update";
        cmd = cmd_for(cmd.tuple);
        send_command(cmd, code);
        wait_done();
        send_lookup(meta_for(cmd.tuple));
        drain_lookups();

        test_name = "fill_to_reject";
        tries = 0;
        code = flow_table_pkg::place_insert;
        while (code != flow_table_pkg::place_reject && tries < 500) begin
            cmd = cmd_for(random_tuple());
            send_command(cmd, code);
            wait_done();
            placed.push_back(cmd.tuple);
            tries++;
        end
        if (code != flow_table_pkg::place_reject) begin
            other_errors++;
            $display("%s: the table never filled up to a reject", test_name);
        end
        foreach (placed[i]) begin
            send_lookup(meta_for(placed[i]));
        end
        drain_lookups();

        test_name = "backpressure";
        stall_mode = 1'b1;
        for (int i = 0; i < 40; i++) begin
            if (xorshift() % 2 == 0) begin
                send_lookup(meta_for(placed[xorshift() % placed.size()]));
            end else begin
                send_lookup(meta_for(random_tuple()));
            end
        end
        drain_lookups();

        // Second command is offered while the first is in flight
        test_name = "control_ready";
        cmd = cmd_for(random_tuple());
        cmd2 = cmd_for(random_tuple());
        send_command(cmd, code);
        send_command(cmd2, code);
        wait_done();
        send_lookup(meta_for(cmd.tuple));
        send_lookup(meta_for(cmd2.tuple));
        drain_lookups();

        repeat (3) @(negedge clk);
        $display("errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* flow_table.f */
+incdir+verilog
+incdir+bench
verilog/flow_table_pkg.sv
verilog/tuple_hash.sv
verilog/flow_subtable.sv
verilog/flow_lookup.sv
verilog/flow_placement.sv
verilog/flow_table.sv
bench/flow_table_tb.sv
